// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module decode_tb -o decode_sim -f tb.f

./obj_dir/decode_sim > sim.log
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: src/branch_resolve.sv
//============================================================================
// branch condition, jump and branch targets, redirect gating
//============================================================================

`timescale 1ns/1ps

module branch_resolve import mips_isa_pkg::*, decode_pkg::*; (
    input  logic     valid,
    input  logic     flush,
    input  word_t    pc,
    input  word_t    pc_plus4,
    input  word_t    inst,
    input  word_t    rs_val,
    input  word_t    rt_val,
    input  br_type_e br_type,
    input  pc_src_e  pc_kind,
    output pc_src_e  pc_src,
    output word_t    br_target,
    output word_t    j_target,
    output word_t    jr_target
);

    logic  eq;
    logic  ltz;
    logic  lez;
    logic  taken;
    word_t br_off;

    // sign tests only look at rs
    assign eq  = (rs_val == rt_val);
    assign ltz = rs_val[xlen_c-1];
    assign lez = ltz || (rs_val == '0);

    always_comb begin
        case (br_type)
            br_eq:   taken = eq;
            br_ne:   taken = !eq;
            br_lez:  taken = lez;
            br_gtz:  taken = !lez;
            br_ltz:  taken = ltz;
            br_gez:  taken = !ltz;
            default: taken = 1'b0;
        endcase
    end

    // word offset, sign extended
    assign br_off    = {{(xlen_c-18){inst[15]}}, inst[15:0], 2'b00};
    assign br_target = pc_plus4 + br_off;
    // region bits come from the instruction's own pc
    assign j_target  = {pc[31:28], inst[25:0], 2'b00};
    assign jr_target = rs_val;

    always_comb begin
        if (!valid || flush) begin
            // no redirect from an empty stage or during exception handling
            pc_src = pc_seq;
        end else if (pc_kind == pc_branch) begin
            pc_src = taken ? pc_branch : pc_seq;
        end else begin
            pc_src = pc_kind;
        end
    end

endmodule

// File: src/decode_control.sv
//============================================================================
// control unit: opcode, funct and regimm decode, reserved-instruction check
//============================================================================

`timescale 1ns/1ps

module decode_control import mips_isa_pkg::*, decode_pkg::*; (
    input  word_t    inst,
    output ctrl_t    ctrl,
    output br_type_e br_type,
    output pc_src_e  pc_kind,
    output logic     exc_ri,
    output logic     exc_sys,
    output logic     exc_bp
);

    opcode_e   opcode;
    funct_e    funct;
    regimm_e   rt_kind;
    reg_addr_t rt;
    reg_addr_t rd;

    assign opcode  = opcode_e'(inst[31:26]);
    assign funct   = funct_e'(inst[5:0]);
    assign rt_kind = regimm_e'(inst[20:16]);
    assign rt      = inst[20:16];
    assign rd      = inst[15:11];

    // register-register group
    function automatic alu_op_e funct_alu(input funct_e fn);
        case (fn)
            fn_subu: funct_alu = alu_sub;
            fn_and:  funct_alu = alu_and;
            fn_or:   funct_alu = alu_or;
            fn_xor:  funct_alu = alu_xor;
            fn_nor:  funct_alu = alu_nor;
            fn_slt:  funct_alu = alu_slt;
            fn_sltu: funct_alu = alu_sltu;
            fn_sll:  funct_alu = alu_sll;
            fn_srl:  funct_alu = alu_srl;
            fn_sra:  funct_alu = alu_sra;
            default: funct_alu = alu_add;
        endcase
    endfunction

    // immediate group
    function automatic alu_op_e imm_alu(input opcode_e op);
        case (op)
            op_slti:  imm_alu = alu_slt;
            op_sltiu: imm_alu = alu_sltu;
            op_andi:  imm_alu = alu_and;
            op_ori:   imm_alu = alu_or;
            op_xori:  imm_alu = alu_xor;
            op_lui:   imm_alu = alu_lui;
            default:  imm_alu = alu_add;
        endcase
    endfunction

    always_comb begin
        // nop by default: add on registers, nothing written
        ctrl         = '0;
        ctrl.wb_addr = rt;
        br_type      = br_none;
        pc_kind      = pc_seq;
        exc_ri       = 1'b0;
        exc_sys      = 1'b0;
        exc_bp       = 1'b0;

        case (opcode)
            op_special: begin
                ctrl.wb_addr = rd;
                case (funct)
                    fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu: begin
                        ctrl.alu_op    = funct_alu(funct);
                        ctrl.reg_write = 1'b1;
                    end
                    fn_sll, fn_srl, fn_sra: begin
                        // shift rt by the sa field
                        ctrl.alu_op    = funct_alu(funct);
                        ctrl.src_a     = src_a_sa;
                        ctrl.reg_write = 1'b1;
                    end
                    fn_jr: pc_kind = pc_jreg;
                    fn_jalr: begin
                        // link pc + 8 into rd
                        pc_kind        = pc_jreg;
                        ctrl.src_a     = src_a_pc;
                        ctrl.src_b     = src_b_eight;
                        ctrl.reg_write = 1'b1;
                    end
                    fn_syscall: exc_sys = 1'b1;
                    fn_break:   exc_bp  = 1'b1;
                    default:    exc_ri  = 1'b1;
                endcase
            end
            op_regimm: begin
                case (rt_kind)
                    rt_bltz: br_type = br_ltz;
                    rt_bgez: br_type = br_gez;
                    default: exc_ri  = 1'b1;
                endcase
            end
            op_j: pc_kind = pc_jump;
            op_jal: begin
                pc_kind        = pc_jump;
                ctrl.src_a     = src_a_pc;
                ctrl.src_b     = src_b_eight;
                ctrl.reg_write = 1'b1;
                ctrl.wb_addr   = ra_reg_c;
            end
            op_beq:  br_type = br_eq;
            op_bne:  br_type = br_ne;
            op_blez: br_type = br_lez;
            op_bgtz: br_type = br_gtz;
            op_addiu, op_slti, op_sltiu: begin
                ctrl.alu_op    = imm_alu(opcode);
                ctrl.src_b     = src_b_simm;
                ctrl.reg_write = 1'b1;
            end
            op_andi, op_ori, op_xori, op_lui: begin
                // logic ops take the zero-extended immediate
                ctrl.alu_op    = imm_alu(opcode);
                ctrl.src_b     = src_b_zimm;
                ctrl.reg_write = 1'b1;
            end
            op_lw: begin
                ctrl.src_b      = src_b_simm;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_en     = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            op_sw: begin
                ctrl.src_b     = src_b_simm;
                ctrl.mem_en    = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            default: exc_ri = 1'b1;
        endcase

        // every conditional branch shares one redirect class
        if (br_type != br_none) begin
            pc_kind = pc_branch;
        end
    end

endmodule

// File: src/decode_pkg.sv
//============================================================================
// decode package: control enums and the structs passed between stages
//============================================================================

package decode_pkg;

    import mips_isa_pkg::*;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or,
        alu_xor, alu_nor, alu_slt, alu_sltu,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    // alu operand a: rs, shift amount, or pc for link
    typedef enum logic [1:0] {
        src_a_reg, src_a_sa, src_a_pc
    } src_a_e;

    // eight is the link offset, pc + 8
    typedef enum logic [1:0] {
        src_b_reg, src_b_simm, src_b_zimm, src_b_eight
    } src_b_e;

    // operand source picked by the hazard unit
    typedef enum logic [1:0] {
        fwd_rf, fwd_exe, fwd_mem, fwd_wb
    } fwd_sel_e;

    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_lez, br_gtz, br_ltz, br_gez
    } br_type_e;

    typedef enum logic [1:0] {
        pc_seq, pc_branch, pc_jump, pc_jreg
    } pc_src_e;

    // execute-stage controls
    typedef struct packed {
        alu_op_e   alu_op;
        src_a_e    src_a;
        src_b_e    src_b;
        logic      reg_write;
        logic      mem_en;
        logic      mem_write;
        logic      mem_to_reg;
        reg_addr_t wb_addr;
    } ctrl_t;

    // exception vector, msb first: adel, ri, sys, bp
    typedef struct packed {
        logic pc_adel;
        logic ri;
        logic sys;
        logic bp;
    } exc_t;

    typedef struct packed {
        word_t inst;
        word_t pc;
        word_t pc_plus4;
        logic  pc_adel;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        exc_t      exc;
        word_t     pc;
        word_t     pc_plus4;
        word_t     rs_val;
        word_t     rt_val;
        word_t     sa;
        word_t     sext_imm;
        word_t     zext_imm;
        reg_addr_t rd;
    } id_exe_t;

endpackage

// File: src/decode_stage.sv
//============================================================================
// decode stage top: control, forwarding, branch resolve and id/exe register
//============================================================================

`timescale 1ns/1ps

module decode_stage import mips_isa_pkg::*, decode_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // fetch side
    input  logic      fetch_valid,
    input  if_id_t    if_id,
    output logic      decode_allowin,
    output logic      decode_stage_valid,
    // register file, answers in the same cycle
    output reg_addr_t rf_raddr1,
    output reg_addr_t rf_raddr2,
    input  word_t     rf_rdata1,
    input  word_t     rf_rdata2,
    // hazard unit
    input  word_t     byp_exe,
    input  word_t     byp_mem,
    input  word_t     byp_wb,
    input  fwd_sel_e  fwd_sel1,
    input  fwd_sel_e  fwd_sel2,
    input  logic      stall,
    input  logic      flush,
    // redirect to fetch
    output pc_src_e   pc_src,
    output word_t     br_target,
    output word_t     j_target,
    output word_t     jr_target,
    // execute side
    input  logic      exe_allowin,
    output logic      exe_valid,
    output id_exe_t   id_exe
);

    ctrl_t    ctrl;
    br_type_e br_type;
    pc_src_e  pc_kind;
    logic     exc_ri;
    logic     exc_sys;
    logic     exc_bp;
    word_t    rs_val;
    word_t    rt_val;
    id_exe_t  next;

    assign rf_raddr1 = if_id.inst[25:21];
    assign rf_raddr2 = if_id.inst[20:16];

    decode_control u_control (
        .inst    (if_id.inst),
        .ctrl    (ctrl),
        .br_type (br_type),
        .pc_kind (pc_kind),
        .exc_ri  (exc_ri),
        .exc_sys (exc_sys),
        .exc_bp  (exc_bp)
    );

    operand_bypass u_bypass (
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .byp_exe   (byp_exe),
        .byp_mem   (byp_mem),
        .byp_wb    (byp_wb),
        .fwd_sel1  (fwd_sel1),
        .fwd_sel2  (fwd_sel2),
        .rs_val    (rs_val),
        .rt_val    (rt_val)
    );

    branch_resolve u_branch (
        .valid     (decode_stage_valid),
        .flush     (flush),
        .pc        (if_id.pc),
        .pc_plus4  (if_id.pc_plus4),
        .inst      (if_id.inst),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .br_type   (br_type),
        .pc_kind   (pc_kind),
        .pc_src    (pc_src),
        .br_target (br_target),
        .j_target  (j_target),
        .jr_target (jr_target)
    );

    // payload for execute
    always_comb begin
        next.ctrl        = ctrl;
        // address error rides along from fetch
        next.exc.pc_adel = if_id.pc_adel;
        next.exc.ri      = exc_ri;
        next.exc.sys     = exc_sys;
        next.exc.bp      = exc_bp;
        next.pc          = if_id.pc;
        next.pc_plus4    = if_id.pc_plus4;
        next.rs_val      = rs_val;
        next.rt_val      = rt_val;
        next.sa          = {{(xlen_c-reg_addr_w_c){1'b0}}, if_id.inst[10:6]};
        next.sext_imm    = {{(xlen_c-16){if_id.inst[15]}}, if_id.inst[15:0]};
        next.zext_imm    = {{(xlen_c-16){1'b0}}, if_id.inst[15:0]};
        next.rd          = if_id.inst[15:11];
    end

    // to_exe_valid stays inside, exe_valid carries it downstream
    id_exe_reg u_id_exe (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid    (fetch_valid),
        .stall          (stall),
        .exe_allowin    (exe_allowin),
        .next           (next),
        .decode_allowin (decode_allowin),
        .to_exe_valid   (),
        .stage_valid    (decode_stage_valid),
        .exe_valid      (exe_valid),
        .id_exe         (id_exe)
    );

endmodule

// File: src/id_exe_reg.sv
//============================================================================
// decode valid bit, allowin handshake and the id/exe pipeline register
//============================================================================

`timescale 1ns/1ps

module id_exe_reg import decode_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    fetch_valid,
    input  logic    stall,
    input  logic    exe_allowin,
    input  id_exe_t next,
    output logic    decode_allowin,
    output logic    to_exe_valid,
    output logic    stage_valid,
    output logic    exe_valid,
    output id_exe_t id_exe
);

    logic valid_q;
    logic transfer;

    // ready to go unless the hazard unit stalls
    assign decode_allowin = !valid_q || (exe_allowin && !stall);
    assign to_exe_valid   = valid_q && !stall;
    assign transfer       = to_exe_valid && exe_allowin;
    assign stage_valid    = valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (decode_allowin) begin
            valid_q <= fetch_valid;
        end
    end

    // execute drains its slot whenever it allows in
    always_ff @(posedge clk) begin
        if (rst) begin
            exe_valid <= 1'b0;
        end else if (exe_allowin) begin
            exe_valid <= to_exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_exe <= '0;
        end else if (transfer) begin
            id_exe <= next;
        end
    end

endmodule

// File: src/mips_isa_pkg.sv
//============================================================================
// mips isa package: field widths, register numbers, opcode and funct codes
//============================================================================

package mips_isa_pkg;

    // datapath and register file widths
    localparam int xlen_c       = 32;
    localparam int reg_addr_w_c = 5;

    typedef logic [xlen_c-1:0]       word_t;
    typedef logic [reg_addr_w_c-1:0] reg_addr_t;

    // jal links here
    localparam reg_addr_t ra_reg_c = reg_addr_t'(31);

    // major opcodes, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_regimm  = 6'h01,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_blez    = 6'h06,
        op_bgtz    = 6'h07,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // special group, inst[5:0]
    typedef enum logic [5:0] {
        fn_sll     = 6'h00,
        fn_srl     = 6'h02,
        fn_sra     = 6'h03,
        fn_jr      = 6'h08,
        fn_jalr    = 6'h09,
        fn_syscall = 6'h0c,
        fn_break   = 6'h0d,
        fn_addu    = 6'h21,
        fn_subu    = 6'h23,
        fn_and     = 6'h24,
        fn_or      = 6'h25,
        fn_xor     = 6'h26,
        fn_nor     = 6'h27,
        fn_slt     = 6'h2a,
        fn_sltu    = 6'h2b
    } funct_e;

    // regimm branches live in the rt field
    typedef enum logic [4:0] {
        rt_bltz = 5'h00,
        rt_bgez = 5'h01
    } regimm_e;

endpackage

// File: src/operand_bypass.sv
//============================================================================
// operand forwarding for rs and rt
//============================================================================

`timescale 1ns/1ps

module operand_bypass import mips_isa_pkg::*, decode_pkg::*; (
    input  word_t    rf_rdata1,
    input  word_t    rf_rdata2,
    input  word_t    byp_exe,
    input  word_t    byp_mem,
    input  word_t    byp_wb,
    input  fwd_sel_e fwd_sel1,
    input  fwd_sel_e fwd_sel2,
    output word_t    rs_val,
    output word_t    rt_val
);

    // hazard unit already picked the newest producer
    function automatic word_t pick(
        input fwd_sel_e sel,
        input word_t    rf,
        input word_t    exe,
        input word_t    mem,
        input word_t    wb
    );
        case (sel)
            fwd_exe: pick = exe;
            fwd_mem: pick = mem;
            fwd_wb:  pick = wb;
            default: pick = rf;
        endcase
    endfunction

    // feeds branch compare, jr target and id/exe
    assign rs_val = pick(fwd_sel1, rf_rdata1, byp_exe, byp_mem, byp_wb);
    assign rt_val = pick(fwd_sel2, rf_rdata2, byp_exe, byp_mem, byp_wb);

endmodule

// File: tb.f
src/mips_isa_pkg.sv
src/decode_pkg.sv
src/decode_control.sv
src/operand_bypass.sv
src/branch_resolve.sv
src/id_exe_reg.sv
src/decode_stage.sv
tests/decode_model_pkg.sv
tests/decode_tb.sv

// File: tests/decode_model_pkg.sv
//============================================================================
// reference model: expected id/exe payload and fetch redirect per instruction
//============================================================================

package decode_model_pkg;

    import mips_isa_pkg::*;
    import decode_pkg::*;

    // expected redirect, target only meaningful for non-sequential kinds
    typedef struct packed {
        pc_src_e pc_src;
        word_t   target;
    } redirect_t;

    // control bundle of an instruction that writes a register
    function automatic ctrl_t alu_ctrl(
        input alu_op_e   op,
        input src_a_e    a,
        input src_b_e    b,
        input reg_addr_t dst
    );
        ctrl_t c;
        c           = '0;
        c.alu_op    = op;
        c.src_a     = a;
        c.src_b     = b;
        c.reg_write = 1'b1;
        c.wb_addr   = dst;
        return c;
    endfunction

    // rs_v and rt_v are the operands after forwarding
    // live is stage valid and no flush
    function automatic void expect_decode(
        input  if_id_t    f,
        input  word_t     rs_v,
        input  word_t     rt_v,
        input  logic      live,
        output id_exe_t   e,
        output redirect_t r
    );
        logic [5:0] op;
        logic [5:0] fn;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic       taken;
        op            = f.inst[31:26];
        fn            = f.inst[5:0];
        rt            = f.inst[20:16];
        rd            = f.inst[15:11];
        taken         = 1'b0;
        e             = '0;
        e.exc.pc_adel = f.pc_adel;
        e.pc          = f.pc;
        e.pc_plus4    = f.pc_plus4;
        e.rs_val      = rs_v;
        e.rt_val      = rt_v;
        e.sa          = 32'(f.inst[10:6]);
        e.sext_imm    = 32'($signed(f.inst[15:0]));
        e.zext_imm    = 32'(f.inst[15:0]);
        e.rd          = rd;
        r.pc_src      = pc_seq;
        r.target      = '0;

        case (op)
            op_special: begin
                case (fn)
                    fn_addu:    e.ctrl = alu_ctrl(alu_add, src_a_reg, src_b_reg, rd);
                    fn_subu:    e.ctrl = alu_ctrl(alu_sub, src_a_reg, src_b_reg, rd);
                    fn_and:     e.ctrl = alu_ctrl(alu_and, src_a_reg, src_b_reg, rd);
                    fn_or:      e.ctrl = alu_ctrl(alu_or, src_a_reg, src_b_reg, rd);
                    fn_xor:     e.ctrl = alu_ctrl(alu_xor, src_a_reg, src_b_reg, rd);
                    fn_nor:     e.ctrl = alu_ctrl(alu_nor, src_a_reg, src_b_reg, rd);
                    fn_slt:     e.ctrl = alu_ctrl(alu_slt, src_a_reg, src_b_reg, rd);
                    fn_sltu:    e.ctrl = alu_ctrl(alu_sltu, src_a_reg, src_b_reg, rd);
                    // shifts take the sa field as operand a
                    fn_sll:     e.ctrl = alu_ctrl(alu_sll, src_a_sa, src_b_reg, rd);
                    fn_srl:     e.ctrl = alu_ctrl(alu_srl, src_a_sa, src_b_reg, rd);
                    fn_sra:     e.ctrl = alu_ctrl(alu_sra, src_a_sa, src_b_reg, rd);
                    fn_jr:      r.pc_src = pc_jreg;
                    fn_jalr: begin
                        e.ctrl   = alu_ctrl(alu_add, src_a_pc, src_b_eight, rd);
                        r.pc_src = pc_jreg;
                    end
                    fn_syscall: e.exc.sys = 1'b1;
                    fn_break:   e.exc.bp = 1'b1;
                    default:    e.exc.ri = 1'b1;
                endcase
            end
            op_regimm: begin
                if (rt[4:1] == 4'd0) begin
                    // rt 0 is bltz, rt 1 is bgez
                    taken    = ($signed(rs_v) < 0) ^ rt[0];
                    r.pc_src = pc_branch;
                end else begin
                    e.exc.ri = 1'b1;
                end
            end
            op_j: r.pc_src = pc_jump;
            op_jal: begin
                e.ctrl   = alu_ctrl(alu_add, src_a_pc, src_b_eight, ra_reg_c);
                r.pc_src = pc_jump;
            end
            op_beq: begin
                taken    = (rs_v == rt_v);
                r.pc_src = pc_branch;
            end
            op_bne: begin
                taken    = (rs_v != rt_v);
                r.pc_src = pc_branch;
            end
            op_blez: begin
                taken    = ($signed(rs_v) <= 0);
                r.pc_src = pc_branch;
            end
            op_bgtz: begin
                taken    = ($signed(rs_v) > 0);
                r.pc_src = pc_branch;
            end
            op_addiu: e.ctrl = alu_ctrl(alu_add, src_a_reg, src_b_simm, rt);
            op_slti:  e.ctrl = alu_ctrl(alu_slt, src_a_reg, src_b_simm, rt);
            op_sltiu: e.ctrl = alu_ctrl(alu_sltu, src_a_reg, src_b_simm, rt);
            op_andi:  e.ctrl = alu_ctrl(alu_and, src_a_reg, src_b_zimm, rt);
            op_ori:   e.ctrl = alu_ctrl(alu_or, src_a_reg, src_b_zimm, rt);
            op_xori:  e.ctrl = alu_ctrl(alu_xor, src_a_reg, src_b_zimm, rt);
            op_lui:   e.ctrl = alu_ctrl(alu_lui, src_a_reg, src_b_zimm, rt);
            op_lw: begin
                e.ctrl            = alu_ctrl(alu_add, src_a_reg, src_b_simm, rt);
                e.ctrl.mem_en     = 1'b1;
                e.ctrl.mem_to_reg = 1'b1;
            end
            op_sw: begin
                // address add only, no register written
                e.ctrl           = alu_ctrl(alu_add, src_a_reg, src_b_simm, rt);
                e.ctrl.reg_write = 1'b0;
                e.ctrl.mem_en    = 1'b1;
                e.ctrl.mem_write = 1'b1;
            end
            default: e.exc.ri = 1'b1;
        endcase

        // untaken branch falls through
        if (r.pc_src == pc_branch && !taken) begin
            r.pc_src = pc_seq;
        end
        case (r.pc_src)
            pc_branch: r.target = f.pc_plus4 + (e.sext_imm << 2);
            pc_jump:   r.target = {f.pc[31:28], f.inst[25:0], 2'b00};
            pc_jreg:   r.target = rs_v;
            default:   r.target = '0;
        endcase
        if (!live) begin
            r.pc_src = pc_seq;
        end
    endfunction

endpackage

// File: tests/decode_tb.sv
//============================================================================
// decode stage testbench: seeded random stimulus, handshake model, scoreboard
//============================================================================

`timescale 1ns/1ps

module decode_tb import mips_isa_pkg::*, decode_pkg::*, decode_model_pkg::*;
();

    logic      clk;
    logic      rst;
    logic      fetch_valid;
    if_id_t    if_id;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     byp_exe;
    word_t     byp_mem;
    word_t     byp_wb;
    fwd_sel_e  fwd_sel1;
    fwd_sel_e  fwd_sel2;
    logic      stall;
    logic      flush;
    logic      exe_allowin;
    logic      decode_allowin;
    logic      decode_stage_valid;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    pc_src_e   pc_src;
    word_t     br_target;
    word_t     j_target;
    word_t     jr_target;
    logic      exe_valid;
    id_exe_t   id_exe;

    // register file contents, answered in the same cycle
    word_t     regs [32];
    id_exe_t   exp_q [$];
    id_exe_t   exp_id;
    // handshake model: decode valid bit and execute valid bit
    logic      vq;
    logic      ev;
    // values seen just before the coming rising edge
    logic      allow_s;
    logic      fv_s;
    logic      ea_s;
    logic      tx_s;
    int        errors;
    int        checks;
    int        timeouts;

    // special appears several times so r-type gets enough traffic
    localparam opcode_e kept_op [20] = '{
        op_special, op_special, op_special, op_special, op_regimm,
        op_j, op_jal, op_beq, op_bne, op_blez, op_bgtz, op_addiu, op_slti,
        op_sltiu, op_andi, op_ori, op_xori, op_lui, op_lw, op_sw
    };
    localparam funct_e kept_fn [15] = '{
        fn_sll, fn_srl, fn_sra, fn_jr, fn_jalr, fn_syscall, fn_break,
        fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu
    };

    assign rf_rdata1 = regs[rf_raddr1];
    assign rf_rdata2 = regs[rf_raddr2];

    decode_stage UUT (
        .clk                (clk),
        .rst                (rst),
        .fetch_valid        (fetch_valid),
        .if_id              (if_id),
        .decode_allowin     (decode_allowin),
        .decode_stage_valid (decode_stage_valid),
        .rf_raddr1          (rf_raddr1),
        .rf_raddr2          (rf_raddr2),
        .rf_rdata1          (rf_rdata1),
        .rf_rdata2          (rf_rdata2),
        .byp_exe            (byp_exe),
        .byp_mem            (byp_mem),
        .byp_wb             (byp_wb),
        .fwd_sel1           (fwd_sel1),
        .fwd_sel2           (fwd_sel2),
        .stall              (stall),
        .flush              (flush),
        .pc_src             (pc_src),
        .br_target          (br_target),
        .j_target           (j_target),
        .jr_target          (jr_target),
        .exe_allowin        (exe_allowin),
        .exe_valid          (exe_valid),
        .id_exe             (id_exe)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [255:0] expv,
                             input logic [255:0] actv);
        checks++;
        assert (expv === actv) else begin
            errors++;
            $display("Fail %s: expected %0h, actual %0h", name, expv, actv);
        end
    endtask

    // ctrl fields with no meaning for the instruction are cleared
    function automatic id_exe_t mask_unused(input id_exe_t v, input ctrl_t ref_c);
        if (!ref_c.reg_write) begin
            v.ctrl.wb_addr = '0;
        end
        if (!ref_c.reg_write && !ref_c.mem_en) begin
            v.ctrl.alu_op = alu_add;
            v.ctrl.src_a  = src_a_reg;
            v.ctrl.src_b  = src_b_reg;
        end
        return v;
    endfunction

    // mostly kept encodings, one in five a raw random word
    function automatic word_t rand_inst();
        word_t w;
        w = $urandom;
        if ($urandom % 5 != 0) begin
            w[31:26] = kept_op[5'($urandom % 20)];
            if (w[31:26] == 6'h00) begin
                w[5:0] = kept_fn[4'($urandom % 15)];
            end
            if (w[31:26] == 6'h01) begin
                w[20:16] = 5'($urandom % 2);
            end
        end
        return w;
    endfunction

    // zero now and then so the sign and equality tests both go either way
    function automatic word_t rand_data();
        return ($urandom % 4 == 0) ? 32'd0 : $urandom;
    endfunction

    function automatic word_t operand(input fwd_sel_e sel, input word_t rf);
        case (sel)
            fwd_exe: return byp_exe;
            fwd_mem: return byp_mem;
            fwd_wb:  return byp_wb;
            default: return rf;
        endcase
    endfunction

    // state change of the last rising edge
    task automatic advance();
        if (allow_s) begin
            vq = fv_s;
        end
        if (ea_s) begin
            ev = tx_s;
        end
        if (tx_s && ea_s) begin
            exp_id = exp_q.pop_front();
        end
    endtask

    // fetch word only changes after decode took the last one
    task automatic drive(input logic quiet);
        if (allow_s) begin
            if_id.inst    = rand_inst();
            if_id.pc      = $urandom;
            if_id.pc_adel = ($urandom % 10 == 0);
            if (!if_id.pc_adel) begin
                if_id.pc[1:0] = 2'b00;
            end
            if_id.pc_plus4 = if_id.pc + 32'd4;
            fetch_valid    = !quiet && ($urandom % 4 != 0);
        end
        stall       = !quiet && ($urandom % 4 == 0);
        exe_allowin = quiet || ($urandom % 4 != 0);
        flush       = !quiet && ($urandom % 7 == 0);
        fwd_sel1    = fwd_sel_e'(2'($urandom));
        fwd_sel2    = fwd_sel_e'(2'($urandom));
        byp_exe     = rand_data();
        byp_mem     = rand_data();
        byp_wb      = rand_data();
    endtask

    // inputs have settled, next rising edge still ahead
    task automatic sample();
        id_exe_t   e;
        redirect_t r;
        allow_s = !vq || (exe_allowin && !stall);
        check_val("decode_allowin", 256'(allow_s), 256'(decode_allowin));
        check_val("decode_stage_valid", 256'(vq), 256'(decode_stage_valid));
        check_val("exe_valid", 256'(ev), 256'(exe_valid));
        check_val("id_exe", 256'(mask_unused(exp_id, exp_id.ctrl)),
                  256'(mask_unused(id_exe, exp_id.ctrl)));
        // read ports follow rs and rt of the held instruction
        if (vq) begin
            check_val("rf_raddr1", 256'(if_id.inst[25:21]), 256'(rf_raddr1));
            check_val("rf_raddr2", 256'(if_id.inst[20:16]), 256'(rf_raddr2));
        end
        expect_decode(if_id, operand(fwd_sel1, regs[if_id.inst[25:21]]),
                      operand(fwd_sel2, regs[if_id.inst[20:16]]), vq && !flush, e, r);
        check_val("pc_src", 256'(r.pc_src), 256'(pc_src));
        case (r.pc_src)
            pc_branch: check_val("br_target", 256'(r.target), 256'(br_target));
            pc_jump:   check_val("j_target", 256'(r.target), 256'(j_target));
            pc_jreg:   check_val("jr_target", 256'(r.target), 256'(jr_target));
            default: ;
        endcase
        fv_s = fetch_valid;
        ea_s = exe_allowin;
        tx_s = vq && !stall;
        if (tx_s && ea_s) begin
            exp_q.push_back(e);
        end
    endtask

    task automatic step(input logic quiet);
        @(negedge clk);
        advance();
        drive(quiet);
        #5;
        sample();
    endtask

    initial begin
        logic drained;
        void'($urandom(94));
        errors      = 0;
        checks      = 0;
        timeouts    = 0;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        if_id       = '0;
        byp_exe     = '0;
        byp_mem     = '0;
        byp_wb      = '0;
        fwd_sel1    = fwd_rf;
        fwd_sel2    = fwd_rf;
        stall       = 1'b0;
        flush       = 1'b0;
        exe_allowin = 1'b1;
        for (int i = 0; i < 32; i++) begin
            regs[i] = (i % 4 == 0) ? 32'd0 : $urandom;
        end
        vq      = 1'b0;
        ev      = 1'b0;
        exp_id  = '0;
        allow_s = 1'b1;
        fv_s    = 1'b0;
        ea_s    = 1'b0;
        tx_s    = 1'b0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #5;
        // empty stage after reset
        check_val("reset decode_allowin", 256'(1'b1), 256'(decode_allowin));
        check_val("reset exe_valid", 256'(1'b0), 256'(exe_valid));
        check_val("reset id_exe", 256'(0), 256'(id_exe));
        check_val("reset pc_src", 256'(pc_seq), 256'(pc_src));

        for (int n = 0; n < 3000; n++) begin
            step(1'b0);
        end

        // no new work, execute always ready; bounded wait for the drain
        drained = 1'b0;
        for (int n = 0; n < 50 && !drained; n++) begin
            step(1'b1);
            drained = !vq && !ev && (exp_q.size() == 0);
        end
        if (!drained) begin
            timeouts++;
            $display("timeout: decode stage did not drain within 50 cycles");
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
